/* sim.f */
+incdir+.
ks_pkg.sv
ks_prefix_tree.sv
ks_decode.sv
ks_execute.sv
ks_result.sv
ks_adder_unit.sv
tb_ks_adder_unit.sv

/* Bender.yml */
package:
  name: ks_adder_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ks_pkg.sv
      - ks_prefix_tree.sv
      - ks_decode.sv
      - ks_execute.sv
      - ks_result.sv
      - ks_adder_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ks_adder_unit.sv

/* tb_ks_adder_unit.sv */
// Testbench for the pipelined Kogge-Stone add/subtract unit
// Reference model feeds a FIFO of expected results and
// concurrent assertions check each result against its head
`timescale 1ns/1ps
`default_nettype none

`include "ks_defines.svh"

module tb_ks_adder_unit
    import ks_pkg::*;
();

    localparam int WIDTH      = `KS_WIDTH;
    localparam int LAT        = `KS_LATENCY;
    localparam int DEPTH      = 16;  // Expected-result FIFO, well above LAT
    localparam int N_RANDOM   = 200;
    localparam int TOTAL_OPS  = 6 + N_RANDOM + 13 + 24 + 9;
    localparam int GAP_MAX    = 18;  // Idle cycles in the back-to-back test
    localparam int NUM_TESTS  = 5;
    localparam int MAX_CYCLES = 4 + 3 + TOTAL_OPS + GAP_MAX + NUM_TESTS * 3 * LAT + 50;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    logic [`KS_OP_W-1:0] op;
    logic [WIDTH-1:0]    a;
    logic [WIDTH-1:0]    b;
    logic                cin;
    logic                out_valid;
    logic [WIDTH-1:0]    sum;
    ks_flags_t           flags;
    logic                err;

    // Expected FIFO, word is {err, flags, sum}
    logic [WIDTH+4:0] exp_word [DEPTH];
    int               exp_cyc  [DEPTH];  // Cycle of the issuing edge
    int               push_cnt = 0;
    int               pop_cnt  = 0;
    logic [WIDTH+4:0] model_word;
    logic [WIDTH+4:0] head_word;
    int               head_cyc;

    int cyc       = 0;
    int fail_cnt  = 0;
    int fail_base = 0;
    int issued    = 0;
    int ops_base  = 0;
    int tests_run = 0;
    int tests_ok  = 0;

    ks_adder_unit dut_i (
        .clk, .rst_n, .in_valid, .op, .a, .b, .cin,
        .out_valid, .sum, .flags, .err
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // Expected result straight from the operation rules
    function automatic logic [WIDTH+4:0] model_op(input logic [`KS_OP_W-1:0] opc,
                                                  input logic [WIDTH-1:0] x,
                                                  input logic [WIDTH-1:0] y,
                                                  input logic c);
        logic [WIDTH-1:0] yy;
        logic             c0;
        logic [WIDTH:0]   full;
        logic [WIDTH-1:0] low;   // Lower bits only, top bit is the carry into the MSB
        logic [WIDTH-1:0] s;
        ks_flags_t        f;
        case (opc)
            OP_ADD:  begin yy = y;  c0 = 1'b0; end
            OP_ADC:  begin yy = y;  c0 = c;    end
            OP_SUB:  begin yy = ~y; c0 = 1'b1; end
            OP_SBC:  begin yy = ~y; c0 = c;    end
            OP_CMP:  begin yy = ~y; c0 = 1'b1; end
            default: return {1'b1, 4'b0000, {WIDTH{1'b0}}};  // Illegal code
        endcase
        full       = {1'b0, x} + {1'b0, yy} + c0;
        low        = {1'b0, x[WIDTH-2:0]} + {1'b0, yy[WIDTH-2:0]} + c0;
        s          = full[WIDTH-1:0];
        f.carry    = full[WIDTH];
        f.zero     = (s == '0);
        f.negative = s[WIDTH-1];
        f.overflow = low[WIDTH-1] ^ full[WIDTH];
        if (opc == OP_CMP) s = '0;  // Flags only
        return {1'b0, f, s};
    endfunction

    function automatic logic [WIDTH-1:0] rand_word();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[WIDTH-1:0];
    endfunction

    assign model_word = model_op(op, a, b, cin);
    assign head_word  = exp_word[pop_cnt % DEPTH];
    assign head_cyc   = exp_cyc[pop_cnt % DEPTH];

    // Cycle counter and watchdog
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", cyc);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Push on the edge that samples the strobe
    always @(posedge clk) begin
        if (rst_n && in_valid) begin
            exp_word[push_cnt % DEPTH] <= model_word;
            exp_cyc[push_cnt % DEPTH]  <= cyc;
            push_cnt                   <= push_cnt + 1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid) pop_cnt <= pop_cnt + 1;  // Pop on delivery
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (!out_valid && !err))
        else begin
            $display("Reset failure at %0t: out_valid or err high during reset", $time);
            fail_cnt = fail_cnt + 1;
        end

    a_no_orphan: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (push_cnt != pop_cnt))
        else begin
            $display("Unexpected result at %0t: out_valid with nothing in flight", $time);
            fail_cnt = fail_cnt + 1;
        end

    a_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && push_cnt != pop_cnt) |-> (cyc == head_cyc + LAT))
        else begin
            $display("MISMATCH at %0t: result after %0d cycles, expected %0d",
                     $time, $sampled(cyc) - $sampled(head_cyc), LAT);
            fail_cnt = fail_cnt + 1;
        end

    a_not_lost: assert property (@(posedge clk) disable iff (!rst_n)
        (push_cnt != pop_cnt && cyc == head_cyc + LAT) |-> out_valid)
        else begin
            $display("Lost result at %0t: out_valid low when a result was due", $time);
            fail_cnt = fail_cnt + 1;
        end

    a_sum: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && push_cnt != pop_cnt) |-> (sum == head_word[WIDTH-1:0]))
        else begin
            $display("MISMATCH at %0t: sum %h, expected %h",
                     $time, $sampled(sum), $sampled(head_word[WIDTH-1:0]));
            fail_cnt = fail_cnt + 1;
        end

    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && push_cnt != pop_cnt) |-> (flags == head_word[WIDTH+3:WIDTH]))
        else begin
            $display("MISMATCH at %0t: flags cznv %b, expected %b",
                     $time, $sampled(flags), $sampled(head_word[WIDTH+3:WIDTH]));
            fail_cnt = fail_cnt + 1;
        end

    a_err: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && push_cnt != pop_cnt) |-> (err == head_word[WIDTH+4]))
        else begin
            $display("MISMATCH at %0t: err %b, expected %b",
                     $time, $sampled(err), $sampled(head_word[WIDTH+4]));
            fail_cnt = fail_cnt + 1;
        end

    // One strobe per call, back-to-back when called in a row
    task automatic issue(input logic [`KS_OP_W-1:0] opc, input logic [WIDTH-1:0] x,
                         input logic [WIDTH-1:0] y, input logic c);
        @(posedge clk);
        in_valid <= 1'b1;
        op       <= opc;
        a        <= x;
        b        <= y;
        cin      <= c;
        issued   = issued + 1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // Wait until every issued operation has come out
    task automatic drain();
        idle(1);
        @(posedge clk);
        while (push_cnt != pop_cnt) @(posedge clk);
        @(posedge clk);
    endtask

    task automatic sub_and_cmp(input logic [WIDTH-1:0] x, input logic [WIDTH-1:0] y);
        issue(OP_SUB, x, y, 1'b0);
        issue(OP_CMP, x, y, 1'b0);
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        if (fail_cnt == fail_base) begin
            tests_ok = tests_ok + 1;
            $display("%s: passed, %0d ops", name, issued - ops_base);
        end else begin
            $display("%s: failed, %0d check failures", name, fail_cnt - fail_base);
        end
        fail_base = fail_cnt;
        ops_base  = issued;
    endtask

    localparam logic [WIDTH-1:0] ONES    = {WIDTH{1'b1}};
    localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};
    localparam logic [WIDTH-1:0] MOST_POS = {1'b0, {(WIDTH-1){1'b1}}};

    initial begin
        in_valid = 1'b0;
        op       = '0;
        a        = '0;
        b        = '0;
        cin      = 1'b0;
        rst_n    = 1'b0;
        void'($urandom(32'hf216_eb6b));  // Single seed for the run

        // Reset held for 4 cycles, then a quiet pipeline
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        idle(3);
        end_test("reset");

        // ADD and ADC corners, then random traffic
        issue(OP_ADD, '0, '0, 1'b0);
        issue(OP_ADD, ONES, 1, 1'b0);       // Wraps to zero with carry
        issue(OP_ADC, ONES, ONES, 1'b1);
        issue(OP_ADC, ONES, ONES, 1'b0);
        issue(OP_ADD, MOST_POS, 1, 1'b0);   // Signed overflow
        issue(OP_ADC, '0, '0, 1'b1);
        for (int i = 0; i < N_RANDOM; i++) begin
            issue($urandom_range(0, 1) ? OP_ADC : OP_ADD, rand_word(), rand_word(),
                  1'($urandom_range(0, 1)));
        end
        drain();
        end_test("add_adc");

        // Subtract family, each SUB paired with a CMP on the same operands
        sub_and_cmp(MOST_NEG, 1);           // Most negative minus 1
        sub_and_cmp(MOST_POS, ONES);        // Most positive minus -1
        sub_and_cmp('0, 1);                 // Borrow
        sub_and_cmp(5, 5);                  // Zero result
        sub_and_cmp(3, 5);
        issue(OP_SBC, 5, 3, 1'b0);
        issue(OP_SBC, '0, '0, 1'b0);        // Borrow in gives all ones
        issue(OP_SBC, MOST_NEG, '0, 1'b0);
        drain();
        end_test("sub_sbc_cmp");

        // Mixed strobes with idle gaps
        for (int i = 0; i < 24; i++) begin
            issue($urandom_range(0, 4), rand_word(), rand_word(), 1'($urandom_range(0, 1)));
            if (i % 4 == 3) idle(1 + i % 3);
        end
        drain();
        end_test("back_to_back");

        // Illegal codes next to legal neighbours
        issue(OP_ADD, 8'h12, 8'h34, 1'b0);
        issue(3'd5, ONES, ONES, 1'b1);
        issue(OP_ADC, 8'h80, 8'h80, 1'b1);
        issue(3'd6, '0, 1, 1'b0);
        issue(OP_SUB, '0, 1, 1'b0);
        issue(3'd7, MOST_NEG, 1, 1'b1);
        issue(3'd5, 1, 1, 1'b0);
        issue(3'd6, ONES, '0, 1'b1);
        issue(3'd7, '0, '0, 1'b0);
        drain();
        end_test("illegal_op");

        $display("tests %0d, passed %0d, ops %0d, check failures %0d",
                 tests_run, tests_ok, issued, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ks_adder_unit.sv */
// Pipelined add/subtract unit, top level
// Decode, execute and result stages around a Kogge-Stone carry network
`timescale 1ns/1ps
`default_nettype none

`include "ks_defines.svh"

module ks_adder_unit
    import ks_pkg::*;
#(
    parameter int WIDTH = `KS_WIDTH
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic [`KS_OP_W-1:0] op,
    input  logic [WIDTH-1:0]    a,
    input  logic [WIDTH-1:0]    b,
    input  logic                cin,
    output logic                out_valid,
    output logic [WIDTH-1:0]    sum,
    output ks_flags_t           flags,
    output logic                err
);

    // Decode to execute
    logic             dec_valid;
    logic [WIDTH-1:0] dec_a;
    logic [WIDTH-1:0] dec_b;
    logic             dec_cin;
    logic             dec_no_sum;
    logic             dec_err;

    // Execute to result
    logic             exe_valid;
    logic [WIDTH-1:0] exe_sum;
    logic             exe_c_msb;
    logic             exe_cout;
    logic             exe_no_sum;
    logic             exe_err;

    ks_decode #(.WIDTH(WIDTH)) decode_i (
        .clk, .rst_n, .in_valid, .op, .a, .b, .cin,
        .dec_valid, .dec_a, .dec_b, .dec_cin, .dec_no_sum, .dec_err
    );

    ks_execute #(.WIDTH(WIDTH)) execute_i (
        .clk, .rst_n,
        .dec_valid, .dec_a, .dec_b, .dec_cin, .dec_no_sum, .dec_err,
        .exe_valid, .exe_sum, .exe_c_msb, .exe_cout, .exe_no_sum, .exe_err
    );

    ks_result #(.WIDTH(WIDTH)) result_i (
        .clk, .rst_n,
        .exe_valid, .exe_sum, .exe_c_msb, .exe_cout, .exe_no_sum, .exe_err,
        .out_valid, .sum, .flags, .err
    );

    // Every issue leaves the pipeline a fixed number of cycles later
    a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##(`KS_LATENCY) out_valid);

endmodule

`default_nettype wire

/* ks_result.sv */
// Result stage of the add/subtract pipeline
// Derives carry, zero, negative and overflow, drops the sum for compares
// and clears sum and flags for illegal opcodes
`timescale 1ns/1ps
`default_nettype none

`include "ks_defines.svh"

module ks_result
    import ks_pkg::*;
#(
    parameter int WIDTH = `KS_WIDTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             exe_valid,
    input  logic [WIDTH-1:0] exe_sum,
    input  logic             exe_c_msb,
    input  logic             exe_cout,
    input  logic             exe_no_sum,
    input  logic             exe_err,
    output logic             out_valid,
    output logic [WIDTH-1:0] sum,
    output ks_flags_t        flags,
    output logic             err
);

    ks_flags_t flags_c;

    always_comb begin
        flags_c.carry    = exe_cout;
        flags_c.zero     = ~|exe_sum;
        flags_c.negative = exe_sum[WIDTH-1];
        flags_c.overflow = exe_c_msb ^ exe_cout; // Signed overflow
    end

    // Control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            err       <= 1'b0;
        end else begin
            out_valid <= exe_valid;
            if (exe_valid) begin
                err <= exe_err;
            end
        end
    end

    // Outputs, cleared per operation type
    always_ff @(posedge clk) begin
        if (exe_valid) begin
            sum   <= (exe_err || exe_no_sum) ? '0 : exe_sum;
            flags <= exe_err ? '0 : flags_c;
        end
    end

endmodule

`default_nettype wire

/* ks_execute.sv */
// Execute stage of the add/subtract pipeline
// Forms bit generate/propagate, folds in the carry-in, runs the
// Kogge-Stone tree and registers the sum with the top two carries
`timescale 1ns/1ps
`default_nettype none

`include "ks_defines.svh"

module ks_execute #(
    parameter int WIDTH = `KS_WIDTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             dec_valid,
    input  logic [WIDTH-1:0] dec_a,
    input  logic [WIDTH-1:0] dec_b,
    input  logic             dec_cin,
    input  logic             dec_no_sum,
    input  logic             dec_err,
    output logic             exe_valid,
    output logic [WIDTH-1:0] exe_sum,
    output logic             exe_c_msb,  // Carry into the top bit
    output logic             exe_cout,   // Carry out of the top bit
    output logic             exe_no_sum,
    output logic             exe_err
);

    logic [WIDTH-1:0] half_sum; // a ^ b
    logic [WIDTH-1:0] bit_g;    // a & b
    logic [WIDTH-1:0] bit_p;    // a | b
    logic [WIDTH-1:0] tree_g;   // Bit 0 generate includes cin
    logic [WIDTH-1:0] carry;    // carry[i] is the carry out of bit i
    logic [WIDTH-1:0] sum_c;

    assign half_sum = dec_a ^ dec_b;
    assign bit_g    = dec_a & dec_b;
    assign bit_p    = dec_a | dec_b;

    // Carry-in absorbed into bit 0, so group generate is the real carry
    assign tree_g = {bit_g[WIDTH-1:1], bit_g[0] | (bit_p[0] & dec_cin)};

    ks_prefix_tree #(
        .WIDTH (WIDTH)
    ) prefix_i (
        .g     (tree_g),
        .p     (bit_p),
        .grp_g (carry),
        .grp_p ()        // Not needed once cin is folded in
    );

    // Carry into each bit, cin at the bottom
    assign sum_c = half_sum ^ {carry[WIDTH-2:0], dec_cin};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe_sum    <= sum_c;
            exe_c_msb  <= carry[WIDTH-2];
            exe_cout   <= carry[WIDTH-1];
            exe_no_sum <= dec_no_sum;
            exe_err    <= dec_err;
        end
    end

    // Pipeline still empty in the first cycle after reset releases
    a_empty_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |=> !exe_valid);

endmodule

`default_nettype wire

/* ks_decode.sv */
// Decode stage of the add/subtract pipeline
// Classifies the opcode, inverts b for subtracts, picks the carry-in
// and flags compares and illegal codes, all registered
`timescale 1ns/1ps
`default_nettype none

`include "ks_defines.svh"

module ks_decode
    import ks_pkg::*;
#(
    parameter int WIDTH = `KS_WIDTH
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,   // One-cycle issue strobe
    input  logic [`KS_OP_W-1:0] op,
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    input  logic               cin,        // External carry-in
    output logic               dec_valid,
    output logic [WIDTH-1:0]   dec_a,
    output logic [WIDTH-1:0]   dec_b,      // Inverted for subtracts
    output logic               dec_cin,
    output logic               dec_no_sum, // Compare, sum is dropped later
    output logic               dec_err     // Illegal opcode
);

    ks_op_e op_e;
    logic   is_sub;    // Subtract family
    logic   cin_sel;   // Carry-in for this operation
    logic   no_sum;
    logic   illegal;

    assign op_e = ks_op_e'(op);

    // Opcode classification
    always_comb begin
        is_sub  = 1'b0;
        cin_sel = 1'b0;
        no_sum  = 1'b0;
        illegal = 1'b0;
        case (op_e)
            OP_ADD: cin_sel = 1'b0;
            OP_ADC: cin_sel = cin;       // Carry from the port
            OP_SUB: begin
                is_sub  = 1'b1;
                cin_sel = 1'b1;          // Two's complement +1
            end
            OP_SBC: begin
                is_sub  = 1'b1;
                cin_sel = cin;           // Borrow from the port
            end
            OP_CMP: begin
                is_sub  = 1'b1;
                cin_sel = 1'b1;
                no_sum  = 1'b1;          // Flags only
            end
            default: illegal = 1'b1;     // Codes 5 to 7
        endcase
    end

    // Valid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // Payload, loaded only on issue
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_a      <= a;
            dec_b      <= is_sub ? ~b : b;
            dec_cin    <= cin_sel;
            dec_no_sum <= no_sum;
            dec_err    <= illegal;
        end
    end

    // An issued opcode must be a known value
    a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(op));

endmodule

`default_nettype wire

/* ks_prefix_tree.sv */
// Kogge-Stone parallel-prefix network
// Combines bit generate/propagate into group terms from bit 0 to each bit
// over log2(WIDTH) levels of doubling span
`timescale 1ns/1ps
`default_nettype none

`include "ks_defines.svh"

module ks_prefix_tree #(
    parameter int WIDTH = `KS_WIDTH
) (
    input  logic [WIDTH-1:0] g,     // Bit generate
    input  logic [WIDTH-1:0] p,     // Bit propagate
    output logic [WIDTH-1:0] grp_g, // Group generate, bits 0..i
    output logic [WIDTH-1:0] grp_p  // Group propagate, bits 0..i
);

    localparam int LEVELS = $clog2(WIDTH);

    // Level k holds terms spanning 2**k bits ending at each position
    logic [LEVELS:0][WIDTH-1:0] lvl_g;
    logic [LEVELS:0][WIDTH-1:0] lvl_p;

    assign lvl_g[0] = g;
    assign lvl_p[0] = p;

    for (genvar k = 1; k <= LEVELS; k++) begin : gen_level
        localparam int SPAN = 1 << (k - 1); // 1, 2, 4 ...

        for (genvar i = 0; i < WIDTH; i++) begin : gen_bit
            if (i >= SPAN) begin : gen_black
                // Merge with the group SPAN bits below
                assign lvl_g[k][i] = lvl_g[k-1][i] | (lvl_p[k-1][i] & lvl_g[k-1][i-SPAN]);
                assign lvl_p[k][i] = lvl_p[k-1][i] & lvl_p[k-1][i-SPAN];
            end else begin : gen_pass
                // Already reaches bit 0
                assign lvl_g[k][i] = lvl_g[k-1][i];
                assign lvl_p[k][i] = lvl_p[k-1][i];
            end
        end
    end

    assign grp_g = lvl_g[LEVELS];
    assign grp_p = lvl_p[LEVELS];

endmodule

`default_nettype wire

/* ks_pkg.sv */
// Types for the Kogge-Stone add/subtract unit
// Opcode encoding and the packed result flags
`default_nettype none

`include "ks_defines.svh"

package ks_pkg;

    // Operation codes, 5 to 7 are illegal
    typedef enum logic [`KS_OP_W-1:0] {
        OP_ADD = 3'd0, // a + b
        OP_ADC = 3'd1, // a + b + cin
        OP_SUB = 3'd2, // a - b
        OP_SBC = 3'd3, // a - b with borrow from cin
        OP_CMP = 3'd4  // Subtract, flags only
    } ks_op_e;

    // Result flags, carry in the top bit
    typedef struct packed {
        logic carry;    // Carry out of the top bit
        logic zero;     // Result is all zeros
        logic negative; // Top bit of the result
        logic overflow; // Signed overflow
    } ks_flags_t;

endpackage

`default_nettype wire

/* ks_defines.svh */
// Shared sizing macros for the Kogge-Stone add/subtract unit
// Data width, opcode width and pipeline latency
`ifndef KS_DEFINES_SVH
`define KS_DEFINES_SVH

// Operand and sum width, any power of two from 4 to 64
`define KS_WIDTH 8

// Opcode field width
`define KS_OP_W 3

// Cycles from the in_valid edge to the out_valid edge
// Decode, execute and result stages, one cycle each
`define KS_LATENCY 3

`endif
